// File: hdl/rename_commit_consts.svh
`ifndef RENAME_COMMIT_CONSTS_SVH
`define RENAME_COMMIT_CONSTS_SVH

// dispatch and retire width, the pair logic assumes two lanes
`define RC_NUM_SUPER 2

// reorder buffer entries
`define RC_NUM_ROB 16

// register counts, free list depth is the difference
`define RC_NUM_ARCH 32
`define RC_NUM_PHYS 48

`endif

// File: hdl/rename_commit_pkg.sv
`default_nettype none

`include "rename_commit_consts.svh"

package rename_commit_pkg;

  // architectural register number
  typedef logic [$clog2(`RC_NUM_ARCH)-1:0] arch_idx_t;

  // physical register tag
  typedef logic [$clog2(`RC_NUM_PHYS)-1:0] tag_t;

  // slot in the reorder buffer
  typedef logic [$clog2(`RC_NUM_ROB)-1:0] rob_idx_t;

  // one reorder buffer slot
  typedef struct packed {
    logic      valid;
    logic      complete;
    logic      halt;
    logic      illegal;
    arch_idx_t dest;
    tag_t      tag;
    tag_t      told;
  } rob_entry_t;

  // draining waits for the older entries to retire after a rollback
  typedef enum logic {
    running,
    draining
  } recovery_state_e;

endpackage

`default_nettype wire

// File: hdl/free_list.sv
`timescale 1ns/10ps
`default_nettype none

`include "rename_commit_consts.svh"

module free_list (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         pop,
  output rename_commit_pkg::tag_t [`RC_NUM_SUPER-1:0]  pop_tag,
  output logic                                         has_pair,
  input  logic [`RC_NUM_SUPER-1:0]                     push_en,
  input  rename_commit_pkg::tag_t [`RC_NUM_SUPER-1:0]  push_tag,
  input  logic                                         refill
);

  localparam int depth = `RC_NUM_PHYS - `RC_NUM_ARCH;
  localparam int ptr_w = $clog2(depth);

  rename_commit_pkg::tag_t queue [depth];

  logic [ptr_w-1:0] rd_ptr, rd_ptr_1;
  logic [ptr_w-1:0] wr_ptr, wr_ptr_1;
  logic [ptr_w:0]   count;
  logic [ptr_w:0]   n_push, n_pop;

  // next two tags always on offer
  assign rd_ptr_1   = rd_ptr + 1'b1;
  assign pop_tag[0] = queue[rd_ptr];
  assign pop_tag[1] = queue[rd_ptr_1];
  assign has_pair   = (count >= 2);

  // lane 1 lands after lane 0 when both push
  assign wr_ptr_1 = wr_ptr + ptr_w'(push_en[0]);
  assign n_push   = (ptr_w+1)'(push_en[0]) + (ptr_w+1)'(push_en[1]);
  assign n_pop    = pop ? (ptr_w+1)'(2) : '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      // tags above the identity mapping start out free
      for (int i = 0; i < depth; i++) begin
        queue[i] <= rename_commit_pkg::tag_t'(`RC_NUM_ARCH + i);
      end
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= (ptr_w+1)'(depth);
    end else if (refill) begin
      // the buffer is empty here, so nothing is pushed or popped
      rd_ptr <= wr_ptr;
      count  <= (ptr_w+1)'(depth);
    end else begin
      if (push_en[0]) begin
        queue[wr_ptr] <= push_tag[0];
      end
      if (push_en[1]) begin
        queue[wr_ptr_1] <= push_tag[1];
      end
      wr_ptr <= wr_ptr + n_push[ptr_w-1:0];
      rd_ptr <= rd_ptr + n_pop[ptr_w-1:0];
      count  <= count + n_push - n_pop;
    end
  end

endmodule

`default_nettype wire

// File: hdl/register_maps.sv
`timescale 1ns/10ps
`default_nettype none

`include "rename_commit_consts.svh"

module register_maps (
  input  logic                                             clock,
  input  logic                                             reset,
  input  logic                                             rename_en,
  input  rename_commit_pkg::arch_idx_t [`RC_NUM_SUPER-1:0] rename_dest,
  input  rename_commit_pkg::tag_t [`RC_NUM_SUPER-1:0]      rename_tag,
  output rename_commit_pkg::tag_t [`RC_NUM_SUPER-1:0]      old_tag,
  input  logic [`RC_NUM_SUPER-1:0]                         commit_en,
  input  rename_commit_pkg::arch_idx_t [`RC_NUM_SUPER-1:0] commit_dest,
  input  rename_commit_pkg::tag_t [`RC_NUM_SUPER-1:0]      commit_tag,
  input  logic                                             restore
);

  // speculative map, looked up at dispatch
  rename_commit_pkg::tag_t spec_map [`RC_NUM_ARCH];

  // architectural map, written at retirement
  rename_commit_pkg::tag_t arch_map [`RC_NUM_ARCH];

  logic same_dest;

  assign same_dest = (rename_dest[1] == rename_dest[0]);

  // lane 1 sees lane 0's new tag when both write one register
  assign old_tag[0] = spec_map[rename_dest[0]];
  assign old_tag[1] = same_dest ? rename_tag[0] : spec_map[rename_dest[1]];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < `RC_NUM_ARCH; r++) begin
        spec_map[r] <= rename_commit_pkg::tag_t'(r);
      end
    end else if (restore) begin
      spec_map <= arch_map;
    end else if (rename_en) begin
      // later assignment wins, so lane 1 takes a shared destination
      spec_map[rename_dest[0]] <= rename_tag[0];
      spec_map[rename_dest[1]] <= rename_tag[1];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < `RC_NUM_ARCH; r++) begin
        arch_map[r] <= rename_commit_pkg::tag_t'(r);
      end
    end else begin
      if (commit_en[0]) begin
        arch_map[commit_dest[0]] <= commit_tag[0];
      end
      // younger retirement overrides on equal destinations
      if (commit_en[1]) begin
        arch_map[commit_dest[1]] <= commit_tag[1];
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "rename_commit_consts.svh"

module reorder_buffer (
  input  logic                                             clock,
  input  logic                                             reset,
  input  logic                                             dispatch_fire,
  input  rename_commit_pkg::arch_idx_t [`RC_NUM_SUPER-1:0] dest_idx,
  input  logic [`RC_NUM_SUPER-1:0]                         halt,
  input  logic [`RC_NUM_SUPER-1:0]                         illegal,
  input  rename_commit_pkg::tag_t [`RC_NUM_SUPER-1:0]      new_tag,
  input  rename_commit_pkg::tag_t [`RC_NUM_SUPER-1:0]      old_tag,
  output logic                                             has_room,
  output rename_commit_pkg::rob_idx_t [`RC_NUM_SUPER-1:0]  rob_idx,
  input  logic [`RC_NUM_SUPER-1:0]                         complete_en,
  input  rename_commit_pkg::rob_idx_t [`RC_NUM_SUPER-1:0]  complete_idx,
  input  logic                                             rollback_en,
  input  rename_commit_pkg::rob_idx_t                      rollback_idx,
  output logic [`RC_NUM_SUPER-1:0]                         retire_en,
  output rename_commit_pkg::arch_idx_t [`RC_NUM_SUPER-1:0] retire_dest,
  output rename_commit_pkg::tag_t [`RC_NUM_SUPER-1:0]      retire_tag,
  output rename_commit_pkg::tag_t [`RC_NUM_SUPER-1:0]      retire_told,
  output logic                                             halt_out,
  output logic                                             illegal_out,
  output logic                                             recovering,
  output logic                                             recover
);

  localparam int cnt_w = $clog2(`RC_NUM_ROB) + 1;

  rename_commit_pkg::rob_entry_t      rob [`RC_NUM_ROB];
  rename_commit_pkg::rob_entry_t      new_entry [`RC_NUM_SUPER];
  rename_commit_pkg::recovery_state_e state;

  rename_commit_pkg::rob_idx_t head, head_1, tail, tail_1;
  rename_commit_pkg::rob_idx_t rollback_1, squash_cnt;

  logic [cnt_w-1:0] count, count_next;
  logic [cnt_w-1:0] n_retire;
  logic             rollback_ok, write_tail;

  assign head_1 = head + 1'b1;
  assign tail_1 = tail + 1'b1;

  assign rob_idx[0] = tail;
  assign rob_idx[1] = tail_1;

  // pair needs two free slots, none reused from this cycle's retirement
  assign has_room   = (state == rename_commit_pkg::running) && (count <= `RC_NUM_ROB - 2);
  assign recovering = (state == rename_commit_pkg::draining);
  assign recover    = recovering && (count == '0);

  // in order, lane 1 only behind lane 0
  assign retire_en[0] = rob[head].valid & rob[head].complete;
  assign retire_en[1] = retire_en[0] & rob[head_1].valid & rob[head_1].complete;

  assign retire_dest[0] = rob[head].dest;
  assign retire_dest[1] = rob[head_1].dest;
  assign retire_tag[0]  = rob[head].tag;
  assign retire_tag[1]  = rob[head_1].tag;
  assign retire_told[0] = rob[head].told;
  assign retire_told[1] = rob[head_1].told;

  assign halt_out    = (retire_en[0] & rob[head].halt) | (retire_en[1] & rob[head_1].halt);
  assign illegal_out = (retire_en[0] & rob[head].illegal) |
                       (retire_en[1] & rob[head_1].illegal);

  // rollback on an entry still in flight
  assign rollback_ok = rollback_en & rob[rollback_idx].valid;
  assign rollback_1  = rollback_idx + 1'b1;
  // entries between the rollback point and the tail
  assign squash_cnt  = tail - rollback_1;

  // a pair dispatched alongside a rollback is younger, so it is dropped
  assign write_tail = dispatch_fire & ~rollback_ok;

  assign n_retire = cnt_w'(retire_en[0]) + cnt_w'(retire_en[1]);

  always_comb begin
    for (int i = 0; i < `RC_NUM_SUPER; i++) begin
      new_entry[i].valid    = 1'b1;
      // halt and illegal never execute
      new_entry[i].complete = halt[i] | illegal[i];
      new_entry[i].halt     = halt[i];
      new_entry[i].illegal  = illegal[i];
      new_entry[i].dest     = dest_idx[i];
      new_entry[i].tag      = new_tag[i];
      new_entry[i].told     = old_tag[i];
    end
  end

  always_comb begin
    count_next = count - n_retire;
    if (write_tail) begin
      count_next = count_next + cnt_w'(2);
    end
    if (rollback_ok) begin
      count_next = count_next - cnt_w'(squash_cnt);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `RC_NUM_ROB; i++) begin
        rob[i].valid    <= 1'b0;
        rob[i].complete <= 1'b0;
      end
      head  <= '0;
      tail  <= '0;
      count <= '0;
      state <= rename_commit_pkg::running;
    end else begin
      for (int i = 0; i < `RC_NUM_SUPER; i++) begin
        if (complete_en[i] && rob[complete_idx[i]].valid) begin
          rob[complete_idx[i]].complete <= 1'b1;
        end
      end

      if (retire_en[0]) begin
        rob[head].valid <= 1'b0;
      end
      if (retire_en[1]) begin
        rob[head_1].valid <= 1'b0;
      end

      if (write_tail) begin
        rob[tail]   <= new_entry[0];
        rob[tail_1] <= new_entry[1];
      end

      // squash from the slot after the rollback point, wrapping past the end
      if (rollback_ok) begin
        for (int i = 0; i < `RC_NUM_ROB; i++) begin
          if (rename_commit_pkg::rob_idx_t'(i - rollback_1) < squash_cnt) begin
            rob[i].valid <= 1'b0;
          end
        end
      end

      head  <= head + n_retire[cnt_w-2:0];
      count <= count_next;

      if (rollback_ok) begin
        tail <= rollback_1;
      end else if (write_tail) begin
        tail <= tail + 2'd2;
      end

      if (rollback_ok) begin
        state <= rename_commit_pkg::draining;
      end else if (recover) begin
        state <= rename_commit_pkg::running;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/rename_commit.sv
`timescale 1ns/10ps
`default_nettype none

`include "rename_commit_consts.svh"

module rename_commit (
  input  logic                                             clock,
  input  logic                                             reset,
  input  logic                                             dispatch_en,
  input  rename_commit_pkg::arch_idx_t [`RC_NUM_SUPER-1:0] dest_idx,
  input  logic [`RC_NUM_SUPER-1:0]                         halt,
  input  logic [`RC_NUM_SUPER-1:0]                         illegal,
  output logic                                             dispatch_ready,
  output rename_commit_pkg::tag_t [`RC_NUM_SUPER-1:0]      disp_tag,
  output rename_commit_pkg::rob_idx_t [`RC_NUM_SUPER-1:0]  disp_rob_idx,
  input  logic [`RC_NUM_SUPER-1:0]                         complete_en,
  input  rename_commit_pkg::rob_idx_t [`RC_NUM_SUPER-1:0]  complete_idx,
  input  logic                                             rollback_en,
  input  rename_commit_pkg::rob_idx_t                      rollback_idx,
  output logic [`RC_NUM_SUPER-1:0]                         retire_en,
  output rename_commit_pkg::arch_idx_t [`RC_NUM_SUPER-1:0] retire_dest,
  output rename_commit_pkg::tag_t [`RC_NUM_SUPER-1:0]      retire_tag,
  output rename_commit_pkg::tag_t [`RC_NUM_SUPER-1:0]      retire_told,
  output logic                                             halt_out,
  output logic                                             illegal_out,
  output logic                                             recovering
);

  rename_commit_pkg::tag_t [`RC_NUM_SUPER-1:0] old_tag;

  logic has_pair, has_room;
  logic dispatch_fire;
  logic recover;

  assign dispatch_ready = has_pair & has_room;
  assign dispatch_fire  = dispatch_en & dispatch_ready;

  // dispatch stage, tags out of the free list
  free_list free_list_i (
    .clock    (clock),
    .reset    (reset),
    .pop      (dispatch_fire),
    .pop_tag  (disp_tag),
    .has_pair (has_pair),
    .push_en  (retire_en),
    .push_tag (retire_told),
    .refill   (recover)
  );

  // renaming and commit of the mappings
  register_maps register_maps_i (
    .clock       (clock),
    .reset       (reset),
    .rename_en   (dispatch_fire),
    .rename_dest (dest_idx),
    .rename_tag  (disp_tag),
    .old_tag     (old_tag),
    .commit_en   (retire_en),
    .commit_dest (retire_dest),
    .commit_tag  (retire_tag),
    .restore     (recover)
  );

  // commit stage
  reorder_buffer reorder_buffer_i (
    .clock         (clock),
    .reset         (reset),
    .dispatch_fire (dispatch_fire),
    .dest_idx      (dest_idx),
    .halt          (halt),
    .illegal       (illegal),
    .new_tag       (disp_tag),
    .old_tag       (old_tag),
    .has_room      (has_room),
    .rob_idx       (disp_rob_idx),
    .complete_en   (complete_en),
    .complete_idx  (complete_idx),
    .rollback_en   (rollback_en),
    .rollback_idx  (rollback_idx),
    .retire_en     (retire_en),
    .retire_dest   (retire_dest),
    .retire_tag    (retire_tag),
    .retire_told   (retire_told),
    .halt_out      (halt_out),
    .illegal_out   (illegal_out),
    .recovering    (recovering),
    .recover       (recover)
  );

endmodule

`default_nettype wire

// File: testbench/rename_commit_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "rename_commit_consts.svh"

module rename_commit_tb;

  localparam int fl_depth = `RC_NUM_PHYS - `RC_NUM_ARCH;

  logic                                             clock;
  logic                                             reset;
  logic                                             dispatch_en;
  rename_commit_pkg::arch_idx_t [`RC_NUM_SUPER-1:0] dest_idx;
  logic [`RC_NUM_SUPER-1:0]                         halt, illegal;
  logic                                             dispatch_ready;
  rename_commit_pkg::tag_t [`RC_NUM_SUPER-1:0]      disp_tag;
  rename_commit_pkg::rob_idx_t [`RC_NUM_SUPER-1:0]  disp_rob_idx;
  logic [`RC_NUM_SUPER-1:0]                         complete_en;
  rename_commit_pkg::rob_idx_t [`RC_NUM_SUPER-1:0]  complete_idx;
  logic                                             rollback_en;
  rename_commit_pkg::rob_idx_t                      rollback_idx;
  logic [`RC_NUM_SUPER-1:0]                         retire_en;
  rename_commit_pkg::arch_idx_t [`RC_NUM_SUPER-1:0] retire_dest;
  rename_commit_pkg::tag_t [`RC_NUM_SUPER-1:0]      retire_tag, retire_told;
  logic                                             halt_out, illegal_out, recovering;

  // model of both maps and the free list queue
  int spec_map [`RC_NUM_ARCH];
  int arch_map [`RC_NUM_ARCH];
  int fl_mem [fl_depth];
  int fl_rd, fl_wr, fl_cnt, rob_tail;
  bit draining;
  // in-flight entries, oldest first
  int q_idx[$], q_dest[$], q_tag[$], q_told[$];
  bit q_done[$], q_halt[$], q_ill[$];
  logic [31:0] seed;

  rename_commit dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic int rand_below(int n);
    seed = seed * 32'd1664525 + 32'd1013904223;
    return int'(seed[31:16]) % n;
  endfunction

  task automatic check_value(logic [31:0] got, logic [31:0] exp, string what);
    assert (got === exp) else begin
      $display("mismatch at time %0t: %s got %0d expected %0d", $time, what, got, exp);
      $display("sim failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic report_timeout(string what);
    $display("timed out at time %0t waiting for %s", $time, what);
    $display("sim failed");
    $fatal(1, "wait timed out");
  endtask

  function automatic int find_entry(int idx);
    for (int i = 0; i < q_idx.size(); i++) begin
      if (q_idx[i] == idx) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic remove_entry(int pos);
    q_idx.delete(pos);
    q_dest.delete(pos);
    q_tag.delete(pos);
    q_told.delete(pos);
    q_done.delete(pos);
    q_halt.delete(pos);
    q_ill.delete(pos);
  endtask

  // checks this cycle's outputs, applies the coming edge to the model, moves on
  task automatic tick();
    bit ready, recover_now;
    int n_ret, rb_pos, e;
    ready = fl_cnt >= 2 && q_idx.size() <= `RC_NUM_ROB - 2 && !draining;
    n_ret = (q_idx.size() > 0 && q_done[0]) ? 1 : 0;
    if (n_ret == 1 && q_idx.size() > 1 && q_done[1]) begin
      n_ret = 2;
    end
    check_value(dispatch_ready, ready, "dispatch_ready");
    check_value(recovering, draining, "recovering");
    check_value(retire_en, (n_ret == 2) ? 3 : n_ret, "retire_en");
    check_value(halt_out, (n_ret > 0 && q_halt[0]) || (n_ret > 1 && q_halt[1]), "halt_out");
    check_value(illegal_out, (n_ret > 0 && q_ill[0]) || (n_ret > 1 && q_ill[1]), "illegal_out");
    for (int l = 0; l < n_ret; l++) begin
      check_value(retire_dest[l], q_dest[l], "retire_dest");
      check_value(retire_tag[l], q_tag[l], "retire_tag");
      check_value(retire_told[l], q_told[l], "retire_told");
    end
    if (dispatch_en && ready) begin
      for (int l = 0; l < 2; l++) begin
        check_value(disp_tag[l], fl_mem[(fl_rd + l) % fl_depth], "disp_tag");
        check_value(disp_rob_idx[l], (rob_tail + l) % `RC_NUM_ROB, "disp_rob_idx");
      end
    end
    recover_now = draining && q_idx.size() == 0;
    rb_pos = rollback_en ? find_entry(rollback_idx) : -1;
    // retired old tags go back to the free list
    for (int l = 0; l < n_ret; l++) begin
      arch_map[q_dest[0]] = q_tag[0];
      fl_mem[fl_wr] = q_told[0];
      fl_wr = (fl_wr + 1) % fl_depth;
      fl_cnt++;
      remove_entry(0);
    end
    for (int l = 0; l < 2; l++) begin
      e = complete_en[l] ? find_entry(complete_idx[l]) : -1;
      if (e >= 0) begin
        q_done[e] = 1'b1;
      end
    end
    if (rb_pos >= 0) begin
      while (q_idx.size() > 0 && q_idx.size() > rb_pos + 1 - n_ret) begin
        remove_entry(q_idx.size() - 1);
      end
      rob_tail = (rollback_idx + 1) % `RC_NUM_ROB;
      draining = 1'b1;
    end else if (dispatch_en && ready) begin
      // lane 1 renamed after lane 0, so it sees lane 0's tag on a shared dest
      for (int l = 0; l < 2; l++) begin
        q_idx.push_back(rob_tail);
        q_dest.push_back(dest_idx[l]);
        q_tag.push_back(fl_mem[fl_rd]);
        q_told.push_back(spec_map[dest_idx[l]]);
        q_done.push_back(halt[l] | illegal[l]);
        q_halt.push_back(halt[l]);
        q_ill.push_back(illegal[l]);
        spec_map[dest_idx[l]] = fl_mem[fl_rd];
        fl_rd = (fl_rd + 1) % fl_depth;
        fl_cnt--;
        rob_tail = (rob_tail + 1) % `RC_NUM_ROB;
      end
    end
    if (recover_now) begin
      spec_map = arch_map;
      fl_rd = fl_wr;
      fl_cnt = fl_depth;
      draining = 1'b0;
    end
    @(posedge clock);
    @(negedge clock);
    dispatch_en = 1'b0;
    complete_en = '0;
    rollback_en = 1'b0;
    halt = '0;
    illegal = '0;
  endtask

  task automatic dispatch_pair(int d0, int d1);
    dispatch_en = 1'b1;
    dest_idx[0] = d0;
    dest_idx[1] = d1;
    tick();
  endtask

  // two completion strobes per cycle
  task automatic complete_list(int idx[$]);
    for (int i = 0; i < idx.size(); i += 2) begin
      complete_en[0] = 1'b1;
      complete_idx[0] = idx[i];
      if (i + 1 < idx.size()) begin
        complete_en[1] = 1'b1;
        complete_idx[1] = idx[i + 1];
      end
      tick();
    end
  endtask

  task automatic shuffle(inout int order[$]);
    int j, t;
    for (int i = order.size() - 1; i > 0; i--) begin
      j = rand_below(i + 1);
      t = order[i];
      order[i] = order[j];
      order[j] = t;
    end
  endtask

  task automatic complete_all_shuffled();
    int order[$];
    order = q_idx;
    shuffle(order);
    complete_list(order);
  endtask

  task automatic wait_idle(int limit);
    int n;
    n = 0;
    while (retire_en != 0 || recovering || q_idx.size() != 0) begin
      if (n == limit) begin
        report_timeout("retirement and recovery to finish");
      end else begin
        tick();
        n++;
      end
    end
  endtask

  task automatic test_first_pairs();
    for (int k = 0; k < 3; k++) begin
      check_value(dispatch_ready, 1, "dispatch_ready after reset");
      check_value(disp_tag[0], 32 + 2 * k, "first tags lane 0");
      check_value(disp_tag[1], 33 + 2 * k, "first tags lane 1");
      check_value(disp_rob_idx[0], 2 * k, "first index lane 0");
      check_value(disp_rob_idx[1], 2 * k + 1, "first index lane 1");
      dispatch_pair(rand_below(32), rand_below(32));
    end
  endtask

  task automatic test_random_order();
    dispatch_pair(5, 5);
    dispatch_pair(rand_below(32), rand_below(32));
    dispatch_pair(9, 9);
    dispatch_pair(rand_below(32), rand_below(32));
    complete_all_shuffled();
    wait_idle(40);
  endtask

  task automatic test_full_buffer();
    int oldest[$];
    for (int k = 0; k < 8; k++) begin
      dispatch_pair(rand_below(32), rand_below(32));
    end
    check_value(dispatch_ready, 0, "dispatch_ready with full buffer");
    // not accepted, later tags and indices show nothing moved
    dispatch_pair(1, 2);
    oldest.push_back(q_idx[0]);
    oldest.push_back(q_idx[1]);
    complete_list(oldest);
    tick();
    check_value(dispatch_ready, 1, "dispatch_ready after oldest pair retired");
    dispatch_pair(rand_below(32), rand_below(32));
    // long-lived entries now hold every free tag
    check_value(dispatch_ready, 0, "dispatch_ready with free list empty");
    complete_all_shuffled();
    wait_idle(40);
  endtask

  task automatic test_rollback();
    int all[$];
    for (int k = 0; k < 4; k++) begin
      dispatch_pair(rand_below(8), rand_below(8));
    end
    all = q_idx;
    rollback_en = 1'b1;
    rollback_idx = q_idx[3];
    tick();
    check_value(recovering, 1, "recovering after rollback");
    // squashed slots get strobes too but must stay retired
    shuffle(all);
    complete_list(all);
    wait_idle(40);
    for (int k = 0; k < 3; k++) begin
      dispatch_pair(rand_below(8), rand_below(8));
    end
    complete_all_shuffled();
    wait_idle(40);
  endtask

  task automatic test_halt_illegal();
    halt = 2'b10;
    illegal = 2'b01;
    dispatch_pair(rand_below(32), rand_below(32));
    check_value(retire_en, 3, "retire_en without completion");
    check_value(halt_out, 1, "halt_out at retirement");
    check_value(illegal_out, 1, "illegal_out at retirement");
    tick();
    check_value(retire_en, 0, "retire_en after halt pair");
  endtask

  initial begin
    seed = 32'h5ee96105;
    reset = 1'b1;
    dispatch_en = 1'b0;
    dest_idx = '0;
    halt = '0;
    illegal = '0;
    complete_en = '0;
    complete_idx = '0;
    rollback_en = 1'b0;
    rollback_idx = '0;
    for (int r = 0; r < `RC_NUM_ARCH; r++) begin
      spec_map[r] = r;
      arch_map[r] = r;
    end
    for (int i = 0; i < fl_depth; i++) begin
      fl_mem[i] = `RC_NUM_ARCH + i;
    end
    fl_rd = 0;
    fl_wr = 0;
    fl_cnt = fl_depth;
    rob_tail = 0;
    draining = 1'b0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    test_first_pairs();
    test_random_order();
    test_full_buffer();
    test_rollback();
    test_halt_illegal();
    wait_idle(20);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rename_commit.f
+incdir+hdl
hdl/rename_commit_pkg.sv
hdl/free_list.sv
hdl/register_maps.sv
hdl/reorder_buffer.sv
hdl/rename_commit.sv
testbench/rename_commit_tb.sv
